//--- hdl/fbtext_cfg.svh
// Framebuffer text engine constants
`ifndef FBTEXT_CFG_SVH
`define FBTEXT_CFG_SVH

// Framebuffer page and glyph geometry
`define FB_BYTES_PER_PAGE 16
`define FB_GLYPH_ROWS     8
`define FB_LINE_GLYPHS    16
`define FB_GLYPH_BLANK    16
`define FB_ADDR_W         27

// PS/2 byte history
`define FB_PS2_DEPTH      8
`define FB_PS2_TEXT_LINE  10

// Supported display resolutions
`define FB_RES_W0         640
`define FB_RES_H0         480
`define FB_RES_W1         800
`define FB_RES_H1         600
`define FB_RES_W2         1024
`define FB_RES_H2         768
`define FB_RES_W3         1280
`define FB_RES_H3         1024

`endif

//--- hdl/fbtext_pkg.sv
// Framebuffer text engine types
`default_nettype none
`include "fbtext_cfg.svh"

package fbtext_pkg;

  // One framebuffer page, byte 0 in the low bits
  typedef logic [`FB_BYTES_PER_PAGE-1:0][7:0] page_t;

  // 0 to 15 are hex digits, 16 is blank
  typedef logic [4:0] glyph_code_t;

  // One text line of glyph codes, glyph 0 leftmost
  typedef glyph_code_t [`FB_LINE_GLYPHS-1:0] glyph_line_t;

  typedef enum logic [2:0] {
    REND_IDLE,
    REND_CLEAR,  // Zero page sweep
    REND_FETCH,  // First ROM lookup of a scanline
    REND_ROW,    // Streaming lookups into the page
    REND_WRITE   // Page presented, waiting on ready
  } render_state_t;

endpackage

`default_nettype wire

//--- hdl/fbtext_top.sv
// Framebuffer text writer top level
`default_nettype none
`include "fbtext_cfg.svh"

module fbtext_top
  import fbtext_pkg::*;
(
  input  logic                  clk200,
  input  logic                  rst200,
  input  logic                  ps2_rx_valid,
  input  logic [7:0]            ps2_rx_data,
  input  logic                  clear_req,
  input  logic [1:0]            res_sel,
  input  logic                  mem_wready,
  output logic                  mem_wvalid,
  output logic [`FB_ADDR_W-1:0] mem_waddr,
  output page_t                 mem_wdata,
  output logic                  busy
);

  logic        line_pending;
  glyph_line_t line_glyphs;
  logic        line_take;

  ps2_hex_line i_ps2_hex_line (
    .clk200       (clk200),
    .rst200       (rst200),
    .ps2_rx_valid (ps2_rx_valid),
    .ps2_rx_data  (ps2_rx_data),
    .line_take    (line_take),
    .line_pending (line_pending),
    .line_glyphs  (line_glyphs)
  );

  // Owns the framebuffer write port and the glyph ROM
  text_renderer i_text_renderer (
    .clk200       (clk200),
    .rst200       (rst200),
    .clear_req    (clear_req),
    .res_sel      (res_sel),
    .line_pending (line_pending),
    .line_glyphs  (line_glyphs),
    .mem_wready   (mem_wready),
    .line_take    (line_take),
    .mem_wvalid   (mem_wvalid),
    .mem_waddr    (mem_waddr),
    .mem_wdata    (mem_wdata),
    .busy         (busy)
  );

endmodule

`default_nettype wire

//--- hdl/glyph_rom.hex
// One 64-bit bitmap per line for glyphs 0 to F and then the blank
// Scanline r of a glyph sits in bits 8r+7 to 8r
003C6666766E663C
007E181818183818
007E60300C06663C
003C66061C06663C
000C0C7E6C3C1C0C
003C6606067C607E
003C6666667C603C
00303030180C067E
003C66663C66663C
00380C063E66663C
0066667E66663C18
007C66667C66667C
003C66606060663C
00786C6666666C78
007E60607C60607E
006060607C60607E
0000000000000000

//--- hdl/glyph_rom.sv
// Hex digit glyph ROM
`default_nettype none
`include "fbtext_cfg.svh"

module glyph_rom
  import fbtext_pkg::*;
(
  input  logic        clk200,
  input  glyph_code_t glyph_code,
  input  logic [2:0]  glyph_row,
  output logic [7:0]  glyph_bits
);

  // Scanline r of a glyph sits in bits [8r+7:8r]
  logic [8*`FB_GLYPH_ROWS-1:0] glyph_mem [0:`FB_GLYPH_BLANK];

  initial begin
    $readmemh("hdl/glyph_rom.hex", glyph_mem);
  end

  always_ff @(posedge clk200) begin
    if (glyph_code <= glyph_code_t'(`FB_GLYPH_BLANK)) begin
      glyph_bits <= glyph_mem[glyph_code][{glyph_row, 3'b000} +: 8];
    end else begin
      glyph_bits <= '0; // Codes past the blank draw nothing
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps2_hex_line.sv
// PS/2 byte history as hex glyphs
`default_nettype none
`include "fbtext_cfg.svh"

module ps2_hex_line
  import fbtext_pkg::*;
(
  input  logic        clk200,
  input  logic        rst200,
  input  logic        ps2_rx_valid,
  input  logic [7:0]  ps2_rx_data,
  input  logic        line_take,
  output logic        line_pending,
  output glyph_line_t line_glyphs
);

  // Glyph codes for hex digits match the nibble value
  function automatic glyph_code_t hex_glyph(input logic [3:0] nibble);
    return {1'b0, nibble};
  endfunction

  // --------------------------------------------------------------------------
  // History shift register
  // --------------------------------------------------------------------------
  // Each byte occupies a pair of slots, newest pair at slots 1:0
  always_ff @(posedge clk200) begin
    if (rst200) begin
      for (int i = 0; i < `FB_LINE_GLYPHS; i++) begin
        line_glyphs[i] <= glyph_code_t'(`FB_GLYPH_BLANK);
      end
    end else if (ps2_rx_valid) begin
      for (int i = `FB_PS2_DEPTH - 1; i > 0; i--) begin
        line_glyphs[i*2 +: 2] <= line_glyphs[(i-1)*2 +: 2];
      end
      line_glyphs[0] <= hex_glyph(ps2_rx_data[3:0]); // Low nibble leftmost
      line_glyphs[1] <= hex_glyph(ps2_rx_data[7:4]);
    end
  end

  // --------------------------------------------------------------------------
  // Redraw request
  // --------------------------------------------------------------------------
  // A new byte wins over a take in the same cycle, so nothing is dropped
  always_ff @(posedge clk200) begin
    if (rst200) begin
      line_pending <= 1'b0;
    end else if (ps2_rx_valid) begin
      line_pending <= 1'b1;
    end else if (line_take) begin
      line_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/text_renderer.sv
// Screen clear and glyph line renderer
`default_nettype none
`include "fbtext_cfg.svh"

module text_renderer
  import fbtext_pkg::*;
(
  input  logic                  clk200,
  input  logic                  rst200,
  input  logic                  clear_req,
  input  logic [1:0]            res_sel,
  input  logic                  line_pending,
  input  glyph_line_t           line_glyphs,
  input  logic                  mem_wready,
  output logic                  line_take,
  output logic                  mem_wvalid,
  output logic [`FB_ADDR_W-1:0] mem_waddr,
  output page_t                 mem_wdata,
  output logic                  busy
);

  localparam int ADDR_W = `FB_ADDR_W;
  localparam int BPP    = `FB_BYTES_PER_PAGE;

  render_state_t     state;
  logic              clr_pend;
  logic [1:0]        res_capt;    // Resolution of the pending clear
  logic [ADDR_W-1:0] pitch;       // Bytes per scanline
  logic [ADDR_W-1:0] clr_last;    // Address of the final clear page
  glyph_line_t       text_capt;
  logic [2:0]        row_idx;
  logic [3:0]        fetch_idx;   // Glyph at the ROM input
  logic [3:0]        place_idx;   // Glyph whose byte leaves the ROM
  glyph_code_t       glyph_code;
  logic [2:0]        glyph_row;
  logic [7:0]        glyph_bits;

  // Width rounded up to whole pages, in bytes
  function automatic logic [ADDR_W-1:0] res_pitch(input logic [1:0] sel);
    int width;
    case (sel)
      2'd0:    width = `FB_RES_W0;
      2'd1:    width = `FB_RES_W1;
      2'd2:    width = `FB_RES_W2;
      default: width = `FB_RES_W3;
    endcase
    return ADDR_W'(((width + 8*BPP - 1) / (8*BPP)) * BPP);
  endfunction

  function automatic logic [ADDR_W-1:0] res_height(input logic [1:0] sel);
    case (sel)
      2'd0:    return ADDR_W'(`FB_RES_H0);
      2'd1:    return ADDR_W'(`FB_RES_H1);
      2'd2:    return ADDR_W'(`FB_RES_H2);
      default: return ADDR_W'(`FB_RES_H3);
    endcase
  endfunction

  assign busy       = (state != REND_IDLE);
  assign line_take  = (state == REND_IDLE) && !clr_pend && line_pending;
  assign glyph_code = text_capt[fetch_idx];
  assign glyph_row  = row_idx;

  glyph_rom i_glyph_rom (
    .clk200     (clk200),
    .glyph_code (glyph_code),
    .glyph_row  (glyph_row),
    .glyph_bits (glyph_bits)
  );

  // --------------------------------------------------------------------------
  // Render FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk200) begin
    if (rst200) begin
      state      <= REND_IDLE;
      clr_pend   <= 1'b0;
      mem_wvalid <= 1'b0;
      pitch      <= res_pitch(2'd0);
      row_idx    <= '0;
      fetch_idx  <= '0;
    end else begin
      case (state)
        REND_IDLE: begin
          if (clr_pend) begin // Clear beats a pending line
            clr_pend   <= 1'b0;
            pitch      <= res_pitch(res_capt);
            clr_last   <= res_height(res_capt) * res_pitch(res_capt) - ADDR_W'(BPP);
            mem_waddr  <= '0;
            mem_wdata  <= '0;
            mem_wvalid <= 1'b1;
            state      <= REND_CLEAR;
          end else if (line_pending) begin
            text_capt <= line_glyphs;
            row_idx   <= '0;
            state     <= REND_FETCH;
          end
        end
        REND_CLEAR: begin
          if (mem_wready) begin
            if (mem_waddr == clr_last) begin
              mem_wvalid <= 1'b0;
              state      <= REND_IDLE;
            end else begin
              mem_waddr <= mem_waddr + ADDR_W'(BPP);
            end
          end
        end
        REND_FETCH: begin
          fetch_idx <= fetch_idx + 1'b1;
          place_idx <= fetch_idx;
          state     <= REND_ROW;
        end
        REND_ROW: begin
          mem_wdata[place_idx] <= glyph_bits;
          fetch_idx            <= fetch_idx + 1'b1;
          place_idx            <= fetch_idx;
          if (place_idx == 4'(`FB_LINE_GLYPHS - 1)) begin
            // Last byte placed, page is complete
            fetch_idx  <= '0;
            mem_waddr  <= (ADDR_W'(`FB_PS2_TEXT_LINE) + ADDR_W'(row_idx)) * pitch;
            mem_wvalid <= 1'b1;
            state      <= REND_WRITE;
          end
        end
        REND_WRITE: begin
          if (mem_wready) begin
            mem_wvalid <= 1'b0;
            if (row_idx == 3'(`FB_GLYPH_ROWS - 1)) begin
              row_idx <= '0;
              state   <= REND_IDLE;
            end else begin
              row_idx <= row_idx + 1'b1;
              state   <= REND_FETCH;
            end
          end
        end
        default: state <= REND_IDLE;
      endcase

      // Late so a new request overrides the take in IDLE
      if (clear_req) begin
        clr_pend <= 1'b1;
        res_capt <= res_sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the text framebuffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fbtext \
  -f vlog.f --Mdir obj_dir -o sim_fbtext

./obj_dir/sim_fbtext > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log

//--- testbench/fbtext_checker.sv
// Framebuffer write checker
`default_nettype none
`include "fbtext_cfg.svh"

module fbtext_checker
  import fbtext_pkg::*;
(
  input  logic                  clk200,
  input  logic                  rst200,
  input  logic                  ps2_rx_valid,
  input  logic [7:0]            ps2_rx_data,
  input  logic                  clear_req,
  input  logic [1:0]            res_sel,
  input  logic                  mem_wvalid,
  input  logic                  mem_wready,
  input  logic [`FB_ADDR_W-1:0] mem_waddr,
  input  page_t                 mem_wdata,
  input  logic                  busy,
  output int                    error_count,
  output int                    write_count,
  output int                    outstanding
);

  logic [8*`FB_GLYPH_ROWS-1:0] font [0:`FB_GLYPH_BLANK];
  logic [`FB_ADDR_W-1:0]       exp_addr_q [$];
  page_t                       exp_data_q [$];
  glyph_line_t                 hist;       // Model of the byte history
  int                          pitch;
  logic                        clr_pend;
  logic [1:0]                  clr_sel;
  logic                        line_pend;
  logic                        busy_d;

  initial begin
    $readmemh("hdl/glyph_rom.hex", font);
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic int width_of(input logic [1:0] sel);
    return (sel == 0) ? `FB_RES_W0 : (sel == 1) ? `FB_RES_W1 :
           (sel == 2) ? `FB_RES_W2 : `FB_RES_W3;
  endfunction

  function automatic int height_of(input logic [1:0] sel);
    return (sel == 0) ? `FB_RES_H0 : (sel == 1) ? `FB_RES_H1 :
           (sel == 2) ? `FB_RES_H2 : `FB_RES_H3;
  endfunction

  // Whole 128-pixel pages per scanline, 16 bytes each
  function automatic int pitch_of(input logic [1:0] sel);
    return ((width_of(sel) + 127) / 128) * 16;
  endfunction

  function automatic page_t text_row(input glyph_line_t line, input int row);
    page_t pg;
    for (int k = 0; k < `FB_LINE_GLYPHS; k++) begin
      pg[k] = font[line[k]][row*8 +: 8];
    end
    return pg;
  endfunction

  task automatic queue_clear(input logic [1:0] sel);
    int pages;
    pitch = pitch_of(sel);
    pages = height_of(sel) * pitch / 16;
    for (int p = 0; p < pages; p++) begin
      exp_addr_q.push_back(`FB_ADDR_W'(p * 16));
      exp_data_q.push_back('0);
    end
  endtask

  task automatic queue_line(input glyph_line_t line);
    for (int r = 0; r < `FB_GLYPH_ROWS; r++) begin
      exp_addr_q.push_back(`FB_ADDR_W'((`FB_PS2_TEXT_LINE + r) * pitch));
      exp_data_q.push_back(text_row(line, r));
    end
  endtask

  task automatic compare_write();
    logic [`FB_ADDR_W-1:0] ea;
    page_t                 ed;
    write_count++;
    if (exp_addr_q.size() == 0) begin
      $display("At %0t the DUT wrote address %0h when no write was expected", $time, mem_waddr);
      error_count++;
    end else begin
      ea = exp_addr_q.pop_front();
      ed = exp_data_q.pop_front();
      if (mem_waddr !== ea) begin
        $display("[FAIL] %0t mem_waddr expected %0h actual %0h", $time, ea, mem_waddr);
        error_count++;
      end
      if (mem_wdata !== ed) begin
        $display("[FAIL] %0t mem_wdata expected %h actual %h", $time, ed, mem_wdata);
        error_count++;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitor
  // --------------------------------------------------------------------------
  always @(posedge clk200) begin
    if (rst200) begin
      for (int i = 0; i < `FB_LINE_GLYPHS; i++) begin
        hist[i] = 5'd16;
      end
      pitch = pitch_of(2'd0);
      clr_pend = 1'b0;
      line_pend = 1'b0;
      busy_d = 1'b0;
      error_count = 0;
      write_count = 0;
      exp_addr_q.delete();
      exp_data_q.delete();
    end else begin
      if (mem_wvalid && mem_wready) compare_write();
      if (busy_d && !busy && exp_addr_q.size() != 0) begin
        $display("At %0t busy fell with %0d writes missing", $time, exp_addr_q.size());
        error_count++;
        exp_addr_q.delete();
        exp_data_q.delete();
      end
      if (!busy) begin // Clear goes first once the renderer is idle
        if (clr_pend) begin
          clr_pend = 1'b0;
          queue_clear(clr_sel);
        end else if (line_pend) begin
          line_pend = 1'b0;
          queue_line(hist);
        end
      end
      if (clear_req) begin
        clr_pend = 1'b1;
        clr_sel  = res_sel;
      end
      if (ps2_rx_valid) begin
        line_pend = 1'b1;
        for (int i = `FB_LINE_GLYPHS - 1; i > 1; i--) begin
          hist[i] = hist[i-2];
        end
        hist[0] = {1'b0, ps2_rx_data[3:0]};
        hist[1] = {1'b0, ps2_rx_data[7:4]};
      end
      busy_d = busy;
    end
    outstanding = exp_addr_q.size();
  end

endmodule

`default_nettype wire

//--- testbench/tb_fbtext.sv
// Text framebuffer writer testbench
`default_nettype none
`include "fbtext_cfg.svh"

module tb_fbtext
  import fbtext_pkg::*;
();

  localparam int TOTAL_WRITES    = 480 * 5 + 8 + 12 * 8 + 600 * 7 + 8;
  localparam int WATCHDOG_CYCLES = TOTAL_WRITES * 4 + 20000; // Line draws need the margin

  logic                  clk200       = 1'b0;
  logic                  rst200       = 1'b1;
  logic                  ps2_rx_valid = 1'b0;
  logic [7:0]            ps2_rx_data  = '0;
  logic                  clear_req    = 1'b0;
  logic [1:0]            res_sel      = '0;
  logic                  mem_wready   = 1'b0;
  logic                  mem_wvalid;
  logic [`FB_ADDR_W-1:0] mem_waddr;
  page_t                 mem_wdata;
  logic                  busy;
  integer                seed         = 32'h7f967ab8;
  logic [31:0]           rand_word    = '0;
  int                    chk_errors;
  int                    chk_writes;
  int                    outstanding;
  int                    tb_errors    = 0;
  int                    err_mark     = 0;
  int                    test_num     = 1;
  int                    failed_tests = 0;

  fbtext_top i_dut (.*);

  fbtext_checker i_checker (
    .clk200       (clk200),
    .rst200       (rst200),
    .ps2_rx_valid (ps2_rx_valid),
    .ps2_rx_data  (ps2_rx_data),
    .clear_req    (clear_req),
    .res_sel      (res_sel),
    .mem_wvalid   (mem_wvalid),
    .mem_wready   (mem_wready),
    .mem_waddr    (mem_waddr),
    .mem_wdata    (mem_wdata),
    .busy         (busy),
    .error_count  (chk_errors),
    .write_count  (chk_writes),
    .outstanding  (outstanding)
  );

  initial begin
    forever #20 clk200 = ~clk200;
  end

  // Framebuffer model with about 70 percent ready
  always @(posedge clk200) begin
    rand_word  <= $random(seed);
    mem_wready <= (rand_word % 100) < 70;
  end

  task automatic drive_requests(input logic clr, input logic [1:0] sel, input logic send,
                                input logic [7:0] b);
    @(posedge clk200);
    clear_req    <= clr;
    res_sel      <= sel;
    ps2_rx_valid <= send;
    ps2_rx_data  <= b;
    @(posedge clk200);
    clear_req    <= 1'b0;
    ps2_rx_valid <= 1'b0;
  endtask

  // Jobs are separated by a single idle cycle
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < 3) begin
      @(posedge clk200);
      quiet = busy ? 0 : quiet + 1;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    @(negedge clk200);
    if (outstanding != 0) begin
      $display("Test %0d ended with %0d expected writes never seen", test_num, outstanding);
      tb_errors++;
    end
    errs = chk_errors + tb_errors - err_mark;
    $display("Test %0d %s: %s with %0d errors", test_num, name, (errs == 0) ? "ok" : "bad", errs);
    if (errs != 0) failed_tests++;
    err_mark = chk_errors + tb_errors;
    test_num++;
  endtask

  initial begin
    repeat (16) @(posedge clk200);
    rst200 <= 1'b0;
    repeat (20) begin
      @(posedge clk200);
      if (mem_wvalid !== 1'b0) begin
        $display("[FAIL] %0t mem_wvalid expected 0 actual %b", $time, mem_wvalid);
        tb_errors++;
      end
      if (busy !== 1'b0) begin
        $display("[FAIL] %0t busy expected 0 actual %b", $time, busy);
        tb_errors++;
      end
    end
    end_test("idle after reset");
    drive_requests(1'b1, 2'd0, 1'b0, 8'h00);
    wait_idle();
    end_test("clear 640x480");
    drive_requests(1'b0, 2'd0, 1'b1, 8'h3A);
    wait_idle();
    end_test("single byte line");
    for (int i = 0; i < 12; i++) begin
      repeat (rand_word[23:16] % 40) @(posedge clk200);
      drive_requests(1'b0, 2'd0, 1'b1, rand_word[31:24]);
    end
    wait_idle();
    end_test("random bytes");
    drive_requests(1'b1, 2'd1, 1'b1, 8'hC5); // Byte left pending behind the clear
    wait_idle();
    end_test("clear 800x600 then line");
    $display("Tests %0d, failed %0d, writes %0d, errors %0d", test_num - 1, failed_tests,
             chk_writes, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk200);
    $display("Watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/fbtext_pkg.sv
hdl/glyph_rom.sv
hdl/ps2_hex_line.sv
hdl/text_renderer.sv
hdl/fbtext_top.sv
testbench/fbtext_checker.sv
testbench/tb_fbtext.sv
